// File: hw/riscvMacros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define RV_XLEN 32
`define RV_MEM_AW 12
`define RV_RESET_PC 32'h0000_0000

// ALU operand A
`define SRCA_PC 2'd0
`define SRCA_REG 2'd1
`define SRCA_ZERO 2'd2
// ALU operand B
`define SRCB_REG 2'd0
`define SRCB_IMM 2'd1
`define SRCB_FOUR 2'd2
`define PCSRC_ALU 2'd0 // Next PC sources
`define PCSRC_ALUREG 2'd1
`define PCSRC_JALR 2'd2
`define WB_ALUREG 2'd0 // Register write data
`define WB_MEM 2'd1
`define WB_PC4 2'd2

`endif

// File: hw/riscvPkg.sv
`include "riscvMacros.svh"

package riscvPkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEM,
		WB,
		HALTED
	} cpuState_t;

	// Major opcodes the core knows
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011 // EBREAK only
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB // LUI
	} aluOp_t;

endpackage

// File: hw/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
	import riscvPkg::*;

	logic irWrite;
	logic pcWrite;
	logic pcWriteCond;
	logic [1:0] aluSrcA; // PC, register A, zero
	logic [1:0] aluSrcB; // Register B, immediate, 4
	aluOp_t aluOp;
	logic [1:0] pcSrc;
	logic [1:0] wbSrc;
	logic regWrite;
	logic memRead;
	logic memWrite;

	// Fields and flags back from the datapath
	opcode_t opcode;
	logic [2:0] funct3;
	logic funct7bit;
	logic aluZero;
	logic branchTrue; // Condition for funct3

	modport ctrl (
		output irWrite, pcWrite, pcWriteCond, aluSrcA, aluSrcB, aluOp, pcSrc, wbSrc,
		output regWrite, memRead, memWrite,
		input opcode, funct3, funct7bit, aluZero, branchTrue
	);

	modport dp (
		input irWrite, pcWrite, pcWriteCond, aluSrcA, aluSrcB, aluOp, pcSrc, wbSrc,
		input regWrite, memRead, memWrite,
		output opcode, funct3, funct7bit, aluZero, branchTrue
	);

endinterface

// File: hw/cpuControl.sv
`timescale 1ns/1ps
`include "riscvMacros.svh"

module cpuControl (
	input logic CLK,
	input logic RSTn,
	ctrlIf.ctrl bus,
	output logic iMemCsn,
	output logic dMemCsn,
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic rfWe,
	output logic halt,
	output riscvPkg::word_t numInst
);
	import riscvPkg::*;

	cpuState_t state;
	cpuState_t nextState;
	logic retire; // Last state of an instruction
	aluOp_t funcOp;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= FETCH;
			numInst <= '0;
		end else begin
			state <= nextState;
			if (retire)
				numInst <= numInst + 1'b1;
		end
	end

	always_comb begin
		nextState = state;
		retire = 1'b0;
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				case (bus.opcode)
					OP_SYSTEM: begin
						nextState = HALTED;
						retire = 1'b1;
					end
					OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
					OP_LOAD, OP_STORE, OP_IMM, OP_REG:
						nextState = EXEC;
					default: begin
						nextState = FETCH; // Unknown opcode retires as a no-op
						retire = 1'b1;
					end
				endcase
			end
			EXEC: begin
				if (bus.opcode == OP_BRANCH) begin
					nextState = FETCH;
					retire = 1'b1;
				end else if (bus.opcode == OP_LOAD || bus.opcode == OP_STORE)
					nextState = MEM;
				else
					nextState = WB;
			end
			MEM: begin
				if (bus.opcode == OP_STORE) begin
					nextState = FETCH;
					retire = 1'b1;
				end else
					nextState = WB;
			end
			WB: begin
				nextState = FETCH;
				retire = 1'b1;
			end
			default: nextState = HALTED; // Left only by reset
		endcase
	end

	always_comb begin
		case (bus.funct3)
			3'b000: funcOp = (bus.opcode == OP_REG && bus.funct7bit) ? ALU_SUB : ALU_ADD;
			3'b001: funcOp = ALU_SLL;
			3'b010: funcOp = ALU_SLT;
			3'b011: funcOp = ALU_SLTU;
			3'b100: funcOp = ALU_XOR;
			3'b101: funcOp = bus.funct7bit ? ALU_SRA : ALU_SRL;
			3'b110: funcOp = ALU_OR;
			default: funcOp = ALU_AND;
		endcase
	end

	always_comb begin
		bus.irWrite = 1'b0;
		bus.pcWrite = 1'b0;
		bus.pcWriteCond = 1'b0;
		bus.regWrite = 1'b0;
		bus.memRead = 1'b0;
		bus.memWrite = 1'b0;
		bus.pcSrc = `PCSRC_ALU;
		bus.aluSrcA = `SRCA_REG;
		bus.aluSrcB = `SRCB_IMM;
		bus.aluOp = ALU_ADD;
		// Execute operands, held through MEM and WB so the ALU register keeps its value
		case (bus.opcode)
			OP_LUI: begin
				bus.aluSrcA = `SRCA_ZERO;
				bus.aluOp = ALU_PASSB;
			end
			OP_AUIPC, OP_JAL: bus.aluSrcA = `SRCA_PC;
			OP_BRANCH: begin
				bus.aluSrcB = `SRCB_REG;
				bus.aluOp = ALU_SUB; // Feeds aluZero
			end
			OP_IMM: bus.aluOp = funcOp;
			OP_REG: begin
				bus.aluSrcB = `SRCB_REG;
				bus.aluOp = funcOp;
			end
			default: ;
		endcase
		case (state)
			FETCH: begin
				bus.irWrite = 1'b1;
				bus.pcWrite = 1'b1;
				bus.aluSrcA = `SRCA_PC;
				bus.aluSrcB = `SRCB_FOUR;
				bus.aluOp = ALU_ADD;
			end
			DECODE: begin
				bus.aluSrcA = `SRCA_PC; // Branch target
				bus.aluSrcB = `SRCB_IMM;
				bus.aluOp = ALU_ADD;
			end
			EXEC: begin
				case (bus.opcode)
					OP_JAL: bus.pcWrite = 1'b1;
					OP_JALR: begin
						bus.pcWrite = 1'b1;
						bus.pcSrc = `PCSRC_JALR;
					end
					OP_BRANCH: begin
						bus.pcWriteCond = 1'b1;
						bus.pcSrc = `PCSRC_ALUREG;
					end
					default: ;
				endcase
			end
			MEM: begin
				bus.memRead = (bus.opcode == OP_LOAD);
				bus.memWrite = (bus.opcode == OP_STORE);
			end
			WB: bus.regWrite = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		case (bus.opcode)
			OP_LOAD: bus.wbSrc = `WB_MEM;
			OP_JAL, OP_JALR: bus.wbSrc = `WB_PC4; // Link value
			default: bus.wbSrc = `WB_ALUREG;
		endcase
	end

	assign iMemCsn = ~bus.irWrite;
	assign dMemCsn = ~(bus.memRead | bus.memWrite);
	assign dMemWen = ~bus.memWrite;
	assign dMemBe = 4'b1111; // Word accesses only
	assign rfWe = bus.regWrite;
	assign halt = (state == HALTED);

endmodule

// File: hw/cpuDatapath.sv
`timescale 1ns/1ps
`include "riscvMacros.svh"

module cpuDatapath (
	input logic CLK,
	input logic RSTn,
	input riscvPkg::word_t iMemDi,
	input riscvPkg::word_t dMemDi,
	input riscvPkg::word_t rfRd1,
	input riscvPkg::word_t rfRd2,
	ctrlIf.dp bus,
	output logic [`RV_MEM_AW-1:0] iMemAddr,
	output logic [`RV_MEM_AW-1:0] dMemAddr,
	output riscvPkg::word_t dMemDout,
	output riscvPkg::regAddr_t rfRa1,
	output riscvPkg::regAddr_t rfRa2,
	output riscvPkg::regAddr_t rfWa,
	output riscvPkg::word_t rfWd,
	output riscvPkg::word_t outputPort
);
	import riscvPkg::*;

	word_t pc;
	word_t oldPc; // PC of the instruction in IR
	word_t ir;
	word_t regA;
	word_t regB;
	word_t aluOut;
	word_t imm;
	word_t opA;
	word_t opB;
	word_t aluResult;
	word_t pcNext;
	word_t jalrTarget;
	logic pcEn;

	always_ff @(posedge CLK) begin
		if (RSTn)
			pc <= `RV_RESET_PC;
		else if (pcEn)
			pc <= pcNext;
	end

	always_ff @(posedge CLK) begin
		if (bus.irWrite) begin
			ir <= iMemDi;
			oldPc <= pc;
		end
		regA <= rfRd1;
		regB <= rfRd2;
		if (!(bus.memRead || bus.memWrite))
			aluOut <= aluResult; // Address stays put during the access
	end

	assign bus.opcode = opcode_t'(ir[6:0]);
	assign bus.funct3 = ir[14:12];
	assign bus.funct7bit = ir[30];
	assign rfRa1 = ir[19:15];
	assign rfRa2 = ir[24:20];
	assign rfWa = ir[11:7];

	always_comb begin
		case (bus.opcode)
			OP_STORE: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			OP_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			OP_LUI, OP_AUIPC: imm = {ir[31:12], 12'b0};
			OP_JAL: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			default: imm = {{20{ir[31]}}, ir[31:20]}; // I format
		endcase
	end

	always_comb begin
		case (bus.aluSrcA)
			`SRCA_PC: opA = bus.irWrite ? pc : oldPc; // Fetch PC until IR is loaded
			`SRCA_REG: opA = regA;
			default: opA = '0;
		endcase
		case (bus.aluSrcB)
			`SRCB_REG: opB = regB;
			`SRCB_IMM: opB = imm;
			default: opB = word_t'(4);
		endcase
	end

	always_comb begin
		case (bus.aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_SLL: aluResult = opA << opB[4:0];
			ALU_SLT: aluResult = word_t'($signed(opA) < $signed(opB));
			ALU_SLTU: aluResult = word_t'(opA < opB);
			ALU_XOR: aluResult = opA ^ opB;
			ALU_SRL: aluResult = opA >> opB[4:0];
			ALU_SRA: aluResult = word_t'($signed(opA) >>> opB[4:0]);
			ALU_OR: aluResult = opA | opB;
			ALU_AND: aluResult = opA & opB;
			default: aluResult = opB;
		endcase
	end

	assign bus.aluZero = (aluResult == '0);

	// Compare on A and B, equality through the subtract
	always_comb begin
		case (bus.funct3)
			3'b000: bus.branchTrue = bus.aluZero;
			3'b001: bus.branchTrue = !bus.aluZero;
			3'b100: bus.branchTrue = $signed(regA) < $signed(regB);
			3'b101: bus.branchTrue = $signed(regA) >= $signed(regB);
			3'b110: bus.branchTrue = regA < regB;
			3'b111: bus.branchTrue = regA >= regB;
			default: bus.branchTrue = 1'b0;
		endcase
	end

	assign jalrTarget = (regA + imm) & ~word_t'(1);
	assign pcEn = bus.pcWrite || (bus.pcWriteCond && bus.branchTrue);

	always_comb begin
		case (bus.pcSrc)
			`PCSRC_ALUREG: pcNext = aluOut;
			`PCSRC_JALR: pcNext = jalrTarget;
			default: pcNext = aluResult;
		endcase
	end

	always_comb begin
		case (bus.wbSrc)
			`WB_MEM: rfWd = dMemDi;
			`WB_PC4: rfWd = oldPc + word_t'(4);
			default: rfWd = aluOut;
		endcase
	end

	assign iMemAddr = pc[`RV_MEM_AW-1:0]; // Byte address
	assign dMemAddr = aluOut[`RV_MEM_AW+1:2]; // Word address
	assign dMemDout = regB;

	always_ff @(posedge CLK) begin
		if (RSTn)
			outputPort <= '0;
		else if (bus.regWrite)
			outputPort <= rfWd;
		else if (bus.pcWriteCond)
			outputPort <= word_t'(bus.branchTrue); // Taken flag
		else if (bus.memWrite)
			outputPort <= word_t'(dMemAddr);
	end

endmodule

// File: hw/riscvTop.sv
`timescale 1ns/1ps
`include "riscvMacros.svh"

module riscvTop (
	input logic CLK,
	input logic RSTn,
	output logic iMemCsn,
	input riscvPkg::word_t iMemDi,
	output logic [`RV_MEM_AW-1:0] iMemAddr, // Byte address
	output logic dMemCsn,
	input riscvPkg::word_t dMemDi,
	output riscvPkg::word_t dMemDout,
	output logic [`RV_MEM_AW-1:0] dMemAddr, // Word address
	output logic dMemWen,
	output logic [3:0] dMemBe,
	output logic rfWe,
	output riscvPkg::regAddr_t rfRa1,
	output riscvPkg::regAddr_t rfRa2,
	output riscvPkg::regAddr_t rfWa,
	input riscvPkg::word_t rfRd1,
	input riscvPkg::word_t rfRd2,
	output riscvPkg::word_t rfWd,
	output logic halt,
	output riscvPkg::word_t numInst,
	output riscvPkg::word_t outputPort
);

	ctrlIf bus ();

	cpuControl control (
		.CLK(CLK),
		.RSTn(RSTn),
		.bus(bus.ctrl),
		.iMemCsn(iMemCsn),
		.dMemCsn(dMemCsn),
		.dMemWen(dMemWen),
		.dMemBe(dMemBe),
		.rfWe(rfWe),
		.halt(halt),
		.numInst(numInst)
	);

	cpuDatapath datapath (
		.CLK(CLK),
		.RSTn(RSTn),
		.iMemDi(iMemDi),
		.dMemDi(dMemDi),
		.rfRd1(rfRd1),
		.rfRd2(rfRd2),
		.bus(bus.dp),
		.iMemAddr(iMemAddr),
		.dMemAddr(dMemAddr),
		.dMemDout(dMemDout),
		.rfRa1(rfRa1),
		.rfRa2(rfRa2),
		.rfWa(rfWa),
		.rfWd(rfWd),
		.outputPort(outputPort)
	);

endmodule

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic CLK,
	output logic RSTn
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // 100 ns period
	end

	initial begin
		RSTn = 1'b1; // Reset level is high
		repeat (5) @(posedge CLK);
		RSTn <= 1'b0;
	end

endmodule

// File: tests/cpuAssert.sv
`timescale 1ns/1ps

module cpuAssert (
	input logic CLK,
	input logic RSTn,
	input logic rfWe,
	input logic dMemWen,
	input logic halt,
	input logic iMemCsn,
	input riscvPkg::cpuState_t state
);
	import riscvPkg::*;

	// Register write and memory write never share a cycle
	assert property (@(posedge CLK) disable iff (RSTn) !(rfWe && !dMemWen))
		else $error("rfWe and dMemWen active together");

	assert property (@(posedge CLK) disable iff (RSTn) halt |=> halt)
		else $error("HALT fell after rising");

	assert property (@(posedge CLK) disable iff (RSTn) !iMemCsn |-> state == FETCH)
		else $error("Instruction fetch outside FETCH");

endmodule

bind cpuControl cpuAssert checks (
	.CLK(CLK),
	.RSTn(RSTn),
	.rfWe(rfWe),
	.dMemWen(dMemWen),
	.halt(halt),
	.iMemCsn(iMemCsn),
	.state(state)
);

// File: tests/tbTop.sv
`timescale 1ns/1ps

module tbTop;
	import riscvPkg::*;

	logic CLK;
	logic RSTn;
	logic iMemCsn;
	logic dMemCsn;
	logic dMemWen;
	logic rfWe;
	logic halt;
	logic [11:0] iMemAddr;
	logic [11:0] dMemAddr;
	logic [3:0] dMemBe;
	word_t iMemDi;
	word_t dMemDi;
	word_t dMemDout;
	word_t rfRd1;
	word_t rfRd2;
	word_t rfWd;
	word_t numInst;
	word_t outputPort;
	regAddr_t rfRa1;
	regAddr_t rfRa2;
	regAddr_t rfWa;

	word_t imem [1024];
	word_t dmem [1024];
	word_t rf [32];
	word_t expReg [32];
	logic expRegValid [32];
	int expMemAddr [$];
	word_t expMemData [$];
	word_t expOut [$];
	word_t expCount;
	int seenCount = 0;
	logic loaded = 1'b0;

	tbClock clockGen (.CLK(CLK), .RSTn(RSTn));

	riscvTop UUT (.*);

	// Combinational reads
	assign iMemDi = imem[iMemAddr[11:2]];
	assign dMemDi = dmem[dMemAddr[9:0]];
	assign rfRd1 = rf[rfRa1];
	assign rfRd2 = rf[rfRa2];

	always @(posedge CLK) begin
		if (!dMemCsn && !dMemWen) begin
			checkWord(word_t'(dMemBe), 32'h0000_000F, "dMemBe"); // Whole words only
			dmem[dMemAddr[9:0]] <= dMemDout;
		end
		if (rfWe && rfWa != 5'd0)
			rf[rfWa] <= rfWd; // x0 stays 0
	end

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic checkCount(input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t numInst: got %0d expected %0d", $time, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Count mismatch");
		end
	endtask

	task automatic loadCases();
		int fd;
		int n;
		int idx;
		byte tag;
		string line;
		word_t val;
		fd = $fopen("tests/programCases.dat", "r");
		if (fd == 0) begin
			$display("Could not open tests/programCases.dat");
			$display("TEST FAILED");
			$fatal(1, "Missing case file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 2 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h", tag, idx, val);
					case (tag)
						"P": imem[idx] = val;
						"D": dmem[idx] = val;
						"R": begin
							expReg[idx] = val;
							expRegValid[idx] = 1'b1;
						end
						"M": begin
							expMemAddr.push_back(idx);
							expMemData.push_back(val);
						end
						"O": expOut.push_back(val);
						"N": expCount = val;
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	initial begin
		for (int i = 0; i < 1024; i++) begin
			imem[i] = 32'h0000_0013 | (word_t'(i) << 20); // addi x0, x0, i
			dmem[i] = 32'hA500_0000 | word_t'(i);
		end
		for (int i = 0; i < 32; i++) begin
			rf[i] = '0;
			expRegValid[i] = 1'b0;
		end
		loadCases();
		loaded = 1'b1;
	end

	// One debug value per retired instruction
	always @(negedge CLK) begin
		if (loaded && !RSTn && numInst != word_t'(seenCount)) begin
			if (seenCount >= expOut.size()) begin
				$display("More instructions retired than the case file lists");
				$display("TEST FAILED");
				$fatal(1, "Extra retirement");
			end else begin
				checkWord(outputPort, expOut[seenCount], $sformatf("outputPort #%0d", seenCount));
				// Next cycle fetches unless EBREAK just retired
				checkWord(word_t'(iMemCsn), word_t'(seenCount == expOut.size() - 1),
					"iMemCsn");
				seenCount++;
			end
		end
	end

	initial begin
		wait (loaded);
		wait (!RSTn);
		wait (halt);
		repeat (3) @(negedge CLK);
		checkWord(word_t'(halt), 32'd1, "halt");
		for (int i = 0; i < 32; i++)
			if (expRegValid[i])
				checkWord(rf[i], expReg[i], $sformatf("x%0d", i));
		foreach (expMemAddr[i])
			checkWord(dmem[expMemAddr[i]], expMemData[i], $sformatf("mem[%0d]", expMemAddr[i]));
		checkCount(numInst, expCount);
		if (seenCount != expOut.size()) begin
			$display("Only %0d of %0d instructions retired", seenCount, expOut.size());
			$display("TEST FAILED");
			$fatal(1, "Short run");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

	// Watchdog
	initial begin
		wait (loaded);
		repeat (int'(expCount) * 5 + 105) @(posedge CLK);
		$display("Timeout: HALT did not rise in the allowed cycles");
		$display("TEST FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: tests/programCases.dat
# tag index value(hex). P program word, D initial data word, R expected register,
# M expected data word, O outputPort per retired instruction, N retired count
P 0 00500093
P 1 FFD00113
P 2 002081B3
P 3 40208233
P 4 001122B3
P 5 00113333
P 6 001093B3
P 7 40115413
P 8 01C15493
P 9 0FF0C513
P A 123455B7
P B 00001617
P C 00708013
P D 00402823
P E 01002683
P F 01402703
P 10 00108463
P 11 00100793
P 12 00109463
P 13 00114463
P 14 00200793
P 15 00115463
P 16 0020E463
P 17 00300793
P 18 0020F463
P 19 0080086F
P 1A 00400793
P 1B 07500893
P 1C 00488967
P 1D 00500793
P 1E 00100073
D 5 CAFEBABE
R 0 00000000
R 1 00000005
R 2 FFFFFFFD
R 3 00000002
R 4 00000008
R 5 00000001
R 6 00000000
R 7 000000A0
R 8 FFFFFFFE
R 9 0000000F
R A 000000FA
R B 12345000
R C 0000102C
R D 00000008
R E CAFEBABE
R F 00000000
R 10 00000068
R 11 00000075
R 12 00000074
M 4 00000008
M 5 CAFEBABE
M 6 A5000006
N 0 1A
O 0 00000005
O 1 FFFFFFFD
O 2 00000002
O 3 00000008
O 4 00000001
O 5 00000000
O 6 000000A0
O 7 FFFFFFFE
O 8 0000000F
O 9 000000FA
O A 12345000
O B 0000102C
O C 0000000C
O D 00000004
O E 00000008
O F CAFEBABE
O 10 00000001
O 11 00000000
O 12 00000001
O 13 00000000
O 14 00000001
O 15 00000000
O 16 00000068
O 17 00000075
O 18 00000074
O 19 00000074

// File: tb.f
+incdir+hw
hw/riscvPkg.sv
hw/ctrlIf.sv
hw/cpuControl.sv
hw/cpuDatapath.sv
hw/riscvTop.sv
tests/tbClock.sv
tests/cpuAssert.sv
tests/tbTop.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= tbTop
FILELIST ?= tb.f
OBJDIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
